//--- hw/l1i_pkg.sv
// L1 instruction cache shared definitions
// Cache geometry, the fetch address seen flat or split into fields,
// the tag memory entry and the line carried from the MAU

package l1i_pkg;

	// --------------------------------------------------
	// Geometry
	// --------------------------------------------------
	// Fetch address and instruction word
	localparam int ADDR_W   = 32;
	localparam int DATA_W   = 32;

	// One line holds four words
	localparam int LINE_W   = 128;
	localparam int OFFSET_W = 4;

	// Set count and the derived field widths
	localparam int SETS     = 64;
	localparam int IDX_W    = 6;
	localparam int TAG_W    = ADDR_W - IDX_W - OFFSET_W;

	// --------------------------------------------------
	// Address views
	// --------------------------------------------------
	// Tag on top, byte offset at the bottom
	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic [IDX_W-1:0]    idx;
		logic [OFFSET_W-1:0] offset;
	} l1i_addr_s;

	// Same word, plain or decoded
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		l1i_addr_s         fields;
	} l1i_addr_u;

	// --------------------------------------------------
	// Storage and MAU payload
	// --------------------------------------------------
	// Entry of one way of the tag memory
	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
	} l1i_tag_entry_s;

	// Full line returned by the MAU in one beat
	typedef struct packed {
		logic [LINE_W-1:0] line;
	} l1i_mau_rsp_s;

endpackage

//--- hw/l1i_tag_mem.sv
// L1I tag memory, one way
// SETS entries of valid bit and tag with a registered read port.
// After reset a sequencer walks all sets and writes invalid entries;
// accesses from the controller are ignored until the walk ends.

`timescale 1ns/1ns

module l1i_tag_mem import l1i_pkg::*; (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           rd_en,
	input  logic           we,
	input  logic [IDX_W-1:0] idx,
	input  l1i_tag_entry_s wentry,
	output l1i_tag_entry_s rentry,
	output logic           clear_done
);

	l1i_tag_entry_s mem [SETS];

	// Clear walk state
	logic [IDX_W-1:0] clr_cnt;
	logic             clr_busy;

	// --------------------------------------------------
	// Post-reset clear sequencer
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clr_cnt  <= '0;
			clr_busy <= 1'b1;
		end else if (clr_busy) begin
			clr_cnt <= clr_cnt + 1'b1;
			// Last set written, walk ends here
			if (clr_cnt == IDX_W'(SETS - 1))
				clr_busy <= 1'b0;
		end
	end

	assign clear_done = !clr_busy;

	// --------------------------------------------------
	// Array and read port
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (clr_busy)
			mem[clr_cnt] <= '0;
		else if (we)
			mem[idx] <= wentry;
	end

	// Output holds during a refill write so compare stays stable
	always_ff @(posedge clk) begin
		if (!clr_busy && rd_en && !we)
			rentry <= mem[idx];
	end

endmodule

//--- hw/l1i_data_mem.sv
// L1I data memory, one way
// SETS lines behind a single synchronous port.
// Write wins over read; the read result is registered.

`timescale 1ns/1ns

module l1i_data_mem import l1i_pkg::*; (
	input  logic             clk,
	input  logic             rd_en,
	input  logic             we,
	input  logic [IDX_W-1:0] idx,
	input  l1i_mau_rsp_s     wline,
	output l1i_mau_rsp_s     rline
);

	// Line storage, contents only meaningful behind a valid tag
	l1i_mau_rsp_s mem [SETS];

	// --------------------------------------------------
	// Single port
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (we) begin
			// Refill from the MAU
			mem[idx] <= wline;
		end else if (rd_en) begin
			// Lookup read, seen in the compare stage
			rline <= mem[idx];
		end
	end

endmodule

//--- hw/l1i_lru.sv
// L1I true-LRU replacement
// Per set, each way carries an age rank, 0 youngest.
// Qualifies tag matches into hit and hit way, otherwise picks the
// victim (lowest invalid way, else oldest) and ages on update.

`timescale 1ns/1ns

module l1i_lru import l1i_pkg::*; #(
	parameter int WAYS = 2
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             lookup,
	input  logic [IDX_W-1:0] idx,
	input  logic [WAYS-1:0]  tag_match,
	input  logic [WAYS-1:0]  tag_valid,
	input  logic             update,
	output logic             hit,
	output logic [WAYS-1:0]  way_vec,
	output logic             lru_ready
);

	localparam int AGE_W = $clog2(WAYS);

	typedef logic [WAYS-1:0][AGE_W-1:0] age_vec_t;

	age_vec_t         age_mem [SETS];
	age_vec_t         cur_age;
	age_vec_t         new_age;
	age_vec_t         init_age;
	logic [IDX_W-1:0] idx_q;
	logic [IDX_W-1:0] clr_cnt;
	logic             clr_busy;
	logic [WAYS-1:0]  hit_vec;
	logic [WAYS-1:0]  victim;
	logic [AGE_W-1:0] used_age;
	logic             found;

	// --------------------------------------------------
	// Index of the request now in compare
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (lookup)
			idx_q <= idx;
	end

	assign cur_age = age_mem[idx_q];

	// --------------------------------------------------
	// Hit, victim and new ranks
	// --------------------------------------------------
	always_comb begin
		hit_vec = tag_match & tag_valid;
		hit     = |hit_vec;
		// Free way first
		found   = 1'b0;
		victim  = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (!tag_valid[w] && !found) begin
				victim[w] = 1'b1;
				found     = 1'b1;
			end
		end
		// All valid, evict the oldest
		if (!found) begin
			for (int w = 0; w < WAYS; w++)
				victim[w] = (cur_age[w] == AGE_W'(WAYS - 1));
		end
		way_vec  = hit ? hit_vec : victim;
		// Rank of the way being touched
		used_age = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (way_vec[w])
				used_age = used_age | cur_age[w];
		end
		// Touched way youngest, younger ones age by one
		for (int w = 0; w < WAYS; w++) begin
			if (way_vec[w])
				new_age[w] = '0;
			else if (cur_age[w] < used_age)
				new_age[w] = cur_age[w] + 1'b1;
			else
				new_age[w] = cur_age[w];
			init_age[w] = AGE_W'(w);
		end
	end

	// --------------------------------------------------
	// Age state and its clear walk
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clr_cnt  <= '0;
			clr_busy <= 1'b1;
		end else if (clr_busy) begin
			clr_cnt <= clr_cnt + 1'b1;
			if (clr_cnt == IDX_W'(SETS - 1))
				clr_busy <= 1'b0;
		end
	end

	// Walk seeds each set with a legal permutation
	always_ff @(posedge clk) begin
		if (clr_busy)
			age_mem[clr_cnt] <= init_age;
		else if (update)
			age_mem[idx_q] <= new_age;
	end

	assign lru_ready = !clr_busy;

endmodule

//--- hw/l1i_ctrl.sv
// L1I controller
// Lookup stage accepts fetches and starts tag, data and LRU reads.
// Compare stage forms the tag match, answers hits and, on a miss,
// runs the MAU handshake and refills the victim way.

`timescale 1ns/1ns

module l1i_ctrl import l1i_pkg::*; #(
	parameter int WAYS = 2
) (
	input  logic             clk,
	input  logic             rst_n,
	// Core side
	input  logic             core_req_valid,
	input  l1i_addr_u        core_req_addr,
	output logic             core_req_ready,
	output logic             core_rsp_valid,
	output logic [DATA_W-1:0] core_rsp_data,
	// MAU side
	output logic             mau_req_valid,
	output l1i_addr_u        mau_req_addr,
	input  logic             mau_req_ready,
	input  logic             mau_rsp_valid,
	input  l1i_mau_rsp_s     mau_rsp,
	// Memory controls
	output logic             mem_rd_en,
	output logic [WAYS-1:0]  mem_we,
	output logic [IDX_W-1:0] mem_idx,
	output l1i_tag_entry_s   tag_wentry,
	// Memory results
	input  l1i_tag_entry_s   tag_rentry [WAYS],
	input  l1i_mau_rsp_s     data_rline [WAYS],
	input  logic [WAYS-1:0]  clear_done,
	// LRU
	output logic             lru_lookup,
	output logic [IDX_W-1:0] lru_idx,
	output logic [WAYS-1:0]  tag_match,
	output logic [WAYS-1:0]  tag_valid,
	output logic             lru_update,
	input  logic             lru_hit,
	input  logic [WAYS-1:0]  lru_way,
	input  logic             lru_ready
);

	typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT, ST_RESP} state_e;

	state_e       state;
	l1i_addr_u    comp_addr;
	logic         comp_valid;
	logic         cleared;
	logic         accept;
	logic         comp_hit;
	logic         comp_miss;
	logic         refill;
	l1i_mau_rsp_s hit_line;
	l1i_mau_rsp_s fill_q;

	// Word of a line by the upper offset bits
	function automatic logic [DATA_W-1:0] pick_word(input l1i_mau_rsp_s l,
		input logic [OFFSET_W-1:0] off);
		logic [OFFSET_W-3:0] w;
		w = off[OFFSET_W-1:2];
		return l.line[w*DATA_W +: DATA_W];
	endfunction

	// --------------------------------------------------
	// Lookup stage
	// --------------------------------------------------
	assign cleared   = (&clear_done) & lru_ready;
	assign comp_hit  = (state == ST_IDLE) && comp_valid && lru_hit;
	assign comp_miss = (state == ST_IDLE) && comp_valid && !lru_hit;
	assign refill    = (state == ST_WAIT) && mau_rsp_valid;

	// Stall while a miss is held in compare
	assign core_req_ready = cleared &&
		(((state == ST_IDLE) && !comp_miss) || (state == ST_RESP));
	assign accept = core_req_valid && core_req_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			comp_valid <= 1'b0;
		else if (core_req_ready)
			comp_valid <= core_req_valid;
	end

	always_ff @(posedge clk) begin
		if (accept)
			comp_addr <= core_req_addr;
	end

	// Shared memory port, lookup index or refill index
	assign mem_rd_en  = accept;
	assign mem_idx    = accept ? core_req_addr.fields.idx : comp_addr.fields.idx;
	assign mem_we     = refill ? lru_way : '0;
	assign tag_wentry = '{valid: 1'b1, tag: comp_addr.fields.tag};
	assign lru_lookup = accept;
	assign lru_idx    = core_req_addr.fields.idx;
	assign lru_update = comp_hit || refill;

	// --------------------------------------------------
	// Compare stage
	// --------------------------------------------------
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			tag_match[w] = (tag_rentry[w].tag == comp_addr.fields.tag);
			tag_valid[w] = tag_rentry[w].valid;
		end
	end

	// Line of the way chosen by the LRU
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (lru_way[w])
				hit_line.line = hit_line.line | data_rline[w].line;
		end
	end

	assign core_rsp_valid = comp_hit || (state == ST_RESP);
	assign core_rsp_data  = pick_word((state == ST_RESP) ? fill_q : hit_line,
		comp_addr.fields.offset);

	// --------------------------------------------------
	// Miss and refill FSM
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (comp_miss) state <= mau_req_ready ? ST_WAIT : ST_REQ;
				ST_REQ:  if (mau_req_ready) state <= ST_WAIT;
				ST_WAIT: if (mau_rsp_valid) state <= ST_RESP;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Line kept for the response cycle
	always_ff @(posedge clk) begin
		if (refill)
			fill_q <= mau_rsp;
	end

	// Request rises in the compare cycle itself
	assign mau_req_valid = comp_miss || (state == ST_REQ);

	always_comb begin
		mau_req_addr = comp_addr;
		mau_req_addr.fields.offset = '0;
	end

endmodule

//--- hw/l1i_top.sv
// L1 instruction cache top level
// Read-only, set-associative, true LRU, two-stage pipeline.
// Ways of tag and data memory, the LRU and the controller.

`timescale 1ns/1ns

module l1i_top import l1i_pkg::*; #(
	parameter int WAYS = 2
) (
	input  logic              clk,
	input  logic              rst_n,
	// Core channel
	input  logic              core_req_valid,
	input  l1i_addr_u         core_req_addr,
	output logic              core_req_ready,
	output logic              core_rsp_valid,
	output logic [DATA_W-1:0] core_rsp_data,
	// MAU channel
	output logic              mau_req_valid,
	output l1i_addr_u         mau_req_addr,
	input  logic              mau_req_ready,
	input  logic              mau_rsp_valid,
	input  l1i_mau_rsp_s      mau_rsp
);

	// Memory controls from the controller
	logic             mem_rd_en;
	logic [WAYS-1:0]  mem_we;
	logic [IDX_W-1:0] mem_idx;
	l1i_tag_entry_s   tag_wentry;

	// Per-way results
	l1i_tag_entry_s   tag_rentry [WAYS];
	l1i_mau_rsp_s     data_rline [WAYS];
	logic [WAYS-1:0]  clear_done;

	// LRU handshake
	logic             lru_lookup;
	logic [IDX_W-1:0] lru_idx;
	logic [WAYS-1:0]  tag_match;
	logic [WAYS-1:0]  tag_valid;
	logic             lru_update;
	logic             lru_hit;
	logic [WAYS-1:0]  lru_way;
	logic             lru_ready;

	// --------------------------------------------------
	// Ways
	// --------------------------------------------------
	for (genvar w = 0; w < WAYS; w++) begin : g_way
		l1i_tag_mem u_tag (
			.clk        (clk),
			.rst_n      (rst_n),
			.rd_en      (mem_rd_en),
			.we         (mem_we[w]),
			.idx        (mem_idx),
			.wentry     (tag_wentry),
			.rentry     (tag_rentry[w]),
			.clear_done (clear_done[w])
		);

		// Refill line comes straight from the MAU
		l1i_data_mem u_data (
			.clk   (clk),
			.rd_en (mem_rd_en),
			.we    (mem_we[w]),
			.idx   (mem_idx),
			.wline (mau_rsp),
			.rline (data_rline[w])
		);
	end

	// --------------------------------------------------
	// Replacement and control
	// --------------------------------------------------
	l1i_lru #(.WAYS(WAYS)) u_lru (
		.clk       (clk),
		.rst_n     (rst_n),
		.lookup    (lru_lookup),
		.idx       (lru_idx),
		.tag_match (tag_match),
		.tag_valid (tag_valid),
		.update    (lru_update),
		.hit       (lru_hit),
		.way_vec   (lru_way),
		.lru_ready (lru_ready)
	);

	l1i_ctrl #(.WAYS(WAYS)) u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.core_req_valid (core_req_valid),
		.core_req_addr  (core_req_addr),
		.core_req_ready (core_req_ready),
		.core_rsp_valid (core_rsp_valid),
		.core_rsp_data  (core_rsp_data),
		.mau_req_valid  (mau_req_valid),
		.mau_req_addr   (mau_req_addr),
		.mau_req_ready  (mau_req_ready),
		.mau_rsp_valid  (mau_rsp_valid),
		.mau_rsp        (mau_rsp),
		.mem_rd_en      (mem_rd_en),
		.mem_we         (mem_we),
		.mem_idx        (mem_idx),
		.tag_wentry     (tag_wentry),
		.tag_rentry     (tag_rentry),
		.data_rline     (data_rline),
		.clear_done     (clear_done),
		.lru_lookup     (lru_lookup),
		.lru_idx        (lru_idx),
		.tag_match      (tag_match),
		.tag_valid      (tag_valid),
		.lru_update     (lru_update),
		.lru_hit        (lru_hit),
		.lru_way        (lru_way),
		.lru_ready      (lru_ready)
	);

endmodule

//--- tb/tb_clk_gen.sv
// Testbench clock and reset generator
// Free-running clock and an active-low reset held for a fixed cycle count

`timescale 1ns/1ns

module tb_clk_gen #(
	parameter int PERIOD     = 100,
	parameter int RST_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	// Clock starts low
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Release just after a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

//--- tb/l1i_props.sv
// L1I interface properties
// Bound into the cache top level. Checks the MAU request hold rule,
// fetch alignment and that every response has an outstanding fetch.

`timescale 1ns/1ns

module l1i_props import l1i_pkg::*; (
	input logic      clk,
	input logic      rst_n,
	input logic      core_req_valid,
	input logic      core_req_ready,
	input l1i_addr_u core_req_addr,
	input logic      core_rsp_valid,
	input logic      mau_req_valid,
	input logic      mau_req_ready,
	input l1i_addr_u mau_req_addr
);

	// Fetches accepted but not yet answered
	int outstanding;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(core_req_valid && core_req_ready)
				- int'(core_rsp_valid);
	end

	// --------------------------------------------------
	// Assertions
	// --------------------------------------------------
	mau_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mau_req_valid && !mau_req_ready |=> mau_req_valid && $stable(mau_req_addr.flat))
		else $error("MAU request dropped or address changed before ready");

	req_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		core_req_valid |-> core_req_addr.fields.offset[1:0] == 2'b00)
		else $error("Core fetch address not word aligned");

	rsp_owed: assert property (@(posedge clk) disable iff (!rst_n)
		core_rsp_valid |-> outstanding > 0)
		else $error("Core response without an outstanding fetch");

endmodule

//--- tb/l1i_tb.sv
// L1I cache testbench
// Drives fetches into the cache, models the MAU and a reference
// set/way cache with true LRU, and checks every response on the fly

`timescale 1ns/1ns

module l1i_tb import l1i_pkg::*; ;

	localparam int WAYS = 2;
	localparam int TMO  = 200;

	logic              clk;
	logic              rst_n;
	logic              req_valid;
	l1i_addr_u         req_addr;
	logic              req_ready;
	logic              rsp_valid;
	logic [DATA_W-1:0] rsp_data;
	logic              mau_valid;
	l1i_addr_u         mau_addr;
	logic              mau_ready;
	logic              mau_rvalid;
	l1i_mau_rsp_s      mau_line;

	// Stimulus and in-flight fetches, oldest first
	logic [ADDR_W-1:0] stim_q [$];
	logic [ADDR_W-1:0] pq_addr [$];
	bit                pq_hit [$];
	int                pq_cyc [$];
	// Hit seen on the DUT per response, in order
	bit                obs_log [$];
	int                cyc;
	int                hs_count;
	int                done_misses;
	bit                fail_shown;
	bit                done_ok;

	// Reference cache state
	bit                m_valid [SETS][WAYS];
	logic [TAG_W-1:0]  m_tag [SETS][WAYS];
	int                m_stamp [SETS][WAYS];
	int                stamp;

	// MAU model state
	int                m_state;
	int                rdy_wait;
	int                rsp_wait;
	logic [ADDR_W-1:0] m_base;

	tb_clk_gen #(.PERIOD(100), .RST_CYCLES(16)) u_clk (.clk(clk), .rst_n(rst_n));

	l1i_top #(.WAYS(WAYS)) DUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.core_req_valid (req_valid),
		.core_req_addr  (req_addr),
		.core_req_ready (req_ready),
		.core_rsp_valid (rsp_valid),
		.core_rsp_data  (rsp_data),
		.mau_req_valid  (mau_valid),
		.mau_req_addr   (mau_addr),
		.mau_req_ready  (mau_ready),
		.mau_rsp_valid  (mau_rvalid),
		.mau_rsp        (mau_line)
	);

	bind l1i_top l1i_props u_props (.*);

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic stop_with_error(input string msg);
		fail_shown = 1'b1;
		$display("test failed");
		$display("%s", msg);
		$fatal(1);
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		fail_shown = 1'b1;
		$display("test failed");
		$display("[ERROR] %s got %h expected %h", name, got, exp);
		$fatal(1);
	endtask

	// Word k of a line is its byte address XOR a fixed pattern
	function automatic logic [LINE_W-1:0] make_line(input logic [ADDR_W-1:0] base);
		logic [LINE_W-1:0] l;
		for (int k = 0; k < 4; k++)
			l[k*DATA_W +: DATA_W] = (base + ADDR_W'(4 * k)) ^ 32'h5a5a0000;
		return l;
	endfunction

	function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] t,
		input logic [IDX_W-1:0] s, input logic [1:0] word);
		return {t, s, word, 2'b00};
	endfunction

	// True LRU by last-use stamps, victim is lowest free way else oldest
	task automatic model_access(input logic [ADDR_W-1:0] a, output bit hit);
		int s;
		int v;
		logic [TAG_W-1:0] t;
		s = int'(a[OFFSET_W +: IDX_W]);
		t = a[ADDR_W-1 -: TAG_W];
		hit = 1'b0;
		v = -1;
		stamp++;
		for (int w = 0; w < WAYS; w++) begin
			if (m_valid[s][w] && m_tag[s][w] == t) begin
				hit = 1'b1;
				v = w;
			end
		end
		if (!hit) begin
			for (int w = WAYS - 1; w >= 0; w--)
				if (!m_valid[s][w])
					v = w;
			if (v < 0) begin
				v = 0;
				for (int w = 1; w < WAYS; w++)
					if (m_stamp[s][w] < m_stamp[s][v])
						v = w;
			end
			m_valid[s][v] = 1'b1;
			m_tag[s][v]   = t;
		end
		m_stamp[s][v] = stamp;
	endtask

	// Entered and left at posedge plus the drive delay
	task automatic issue_all(input bit gaps);
		int tmo;
		bit taken;
		while (stim_q.size() > 0) begin
			if (gaps && ($urandom % 4 == 0)) begin
				req_valid = 1'b0;
				@(posedge clk);
				#5;
			end
			req_valid     = 1'b1;
			req_addr.flat = stim_q.pop_front();
			tmo   = 0;
			taken = 1'b0;
			while (!taken) begin
				@(negedge clk);
				if (req_ready) begin
					taken = 1'b1;
				end else begin
					tmo++;
					if (tmo > TMO)
						stop_with_error("Timeout: fetch never accepted");
				end
			end
			@(posedge clk);
			#5;
		end
		req_valid = 1'b0;
	endtask

	task automatic drain_pending();
		int tmo;
		tmo = 0;
		while (pq_addr.size() > 0) begin
			@(negedge clk);
			tmo++;
			if (tmo > TMO)
				stop_with_error("Timeout: response never arrived");
		end
		@(posedge clk);
		#5;
	endtask

	// --------------------------------------------------
	// MAU model
	// --------------------------------------------------
	always begin
		@(posedge clk);
		#5;
		mau_ready  = 1'b0;
		mau_rvalid = 1'b0;
		if (!rst_n) begin
			m_state = 0;
		end else begin
			if (m_state == 0 && mau_valid) begin
				rdy_wait = int'($urandom % 4);
				m_state  = 1;
			end
			if (m_state == 1) begin
				if (rdy_wait == 0) begin
					mau_ready = 1'b1;
					m_base    = mau_addr.flat;
					hs_count++;
					rsp_wait  = 1 + int'($urandom % 6);
					m_state   = 2;
				end else begin
					rdy_wait--;
				end
			end else if (m_state == 2) begin
				rsp_wait--;
				if (rsp_wait == 0) begin
					mau_rvalid    = 1'b1;
					mau_line.line = make_line(m_base);
					m_state       = 0;
				end
			end
		end
	end

	// --------------------------------------------------
	// Monitor and checks, mid-cycle
	// --------------------------------------------------
	always @(negedge clk) begin
		bit h;
		if (rst_n) begin
			cyc++;
			if (mau_valid) begin
				assert (pq_addr.size() > 0 && !pq_hit[0])
					else stop_with_error("MAU request without a predicted miss");
				assert (mau_addr.flat == {pq_addr[0][ADDR_W-1:OFFSET_W], 4'h0})
					else value_error("mau_req_addr", mau_addr.flat,
						{pq_addr[0][ADDR_W-1:OFFSET_W], 4'h0});
			end
			if (rsp_valid) begin
				assert (pq_addr.size() > 0)
					else stop_with_error("Response with no fetch pending");
				if (!pq_hit[0])
					done_misses++;
				else
					assert (cyc == pq_cyc[0] + 1)
						else stop_with_error("Hit response not one cycle after acceptance");
				assert (hs_count == done_misses)
					else value_error("mau handshakes", hs_count, done_misses);
				assert (rsp_data == (pq_addr[0] ^ 32'h5a5a0000))
					else value_error("core_rsp_data", rsp_data, pq_addr[0] ^ 32'h5a5a0000);
				// Only a hit answers in the cycle after acceptance
				obs_log.push_back(cyc == pq_cyc[0] + 1);
				void'(pq_addr.pop_front());
				void'(pq_hit.pop_front());
				void'(pq_cyc.pop_front());
			end
			// New fetch enters the reference model in order
			if (req_valid && req_ready) begin
				model_access(req_addr.flat, h);
				pq_addr.push_back(req_addr.flat);
				pq_hit.push_back(h);
				pq_cyc.push_back(cyc);
			end
		end
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		int n;
		int tmo;
		logic [ADDR_W-1:0] base;
		void'($urandom(32'h443f1d00));
		req_valid  = 1'b0;
		req_addr   = '0;
		mau_ready  = 1'b0;
		mau_rvalid = 1'b0;
		mau_line   = '0;

		repeat (4) @(negedge clk);
		assert (!req_ready && !rsp_valid && !mau_valid)
			else stop_with_error("Outputs not idle during reset");
		tmo = 0;
		while (!rst_n) begin
			@(negedge clk);
			tmo++;
			if (tmo > TMO)
				stop_with_error("Timeout: reset never released");
		end

		// Ready only after the clear walk over all sets
		n = 0;
		while (1) begin
			@(posedge clk);
			n++;
			@(negedge clk);
			if (req_ready)
				break;
			if (n > TMO)
				stop_with_error("Timeout: core_req_ready never rose");
		end
		assert (n == SETS) else value_error("clear cycles", n, SETS);
		@(posedge clk);
		#5;

		// Cold miss, then back-to-back hits on all offsets
		base = make_addr(22'h000123, 6'd3, 2'd0);
		stim_q = '{base, base + 4, base + 8, base + 12, base};
		issue_all(1'b0);
		drain_pending();
		n = obs_log.size();
		assert (!obs_log[0] && obs_log[n-1] && obs_log[n-2] && obs_log[n-3]
			&& obs_log[n-4]) else stop_with_error("Resident line fetches did not hit");

		// LRU order in one set: A B A C, then A hits and B misses
		stim_q = '{make_addr(22'h1, 6'd20, 2'd0), make_addr(22'h2, 6'd20, 2'd1),
			make_addr(22'h1, 6'd20, 2'd2), make_addr(22'h3, 6'd20, 2'd3),
			make_addr(22'h1, 6'd20, 2'd1), make_addr(22'h2, 6'd20, 2'd2)};
		issue_all(1'b0);
		drain_pending();
		n = obs_log.size();
		assert (obs_log[n-2] && !obs_log[n-1])
			else stop_with_error("LRU sequence gave the wrong hit and miss order");

		// Random fetches over a few sets and tags
		for (int i = 0; i < 300; i++)
			stim_q.push_back(make_addr(TAG_W'(32'h100 + $urandom % 4),
				IDX_W'(40 + $urandom % 3), 2'($urandom % 4)));
		issue_all(1'b1);
		drain_pending();

		if (fail_shown) begin
			$display("test failed");
			$fatal(1);
		end else begin
			done_ok = 1'b1;
			$display("test passed");
			$finish;
		end
	end

	// Run stopped by a failed property
	final begin
		if (!done_ok && !fail_shown)
			$display("test failed");
	end

endmodule

//--- sources.f
hw/l1i_pkg.sv
hw/l1i_tag_mem.sv
hw/l1i_data_mem.sv
hw/l1i_lru.sv
hw/l1i_ctrl.sv
hw/l1i_top.sv
tb/tb_clk_gen.sv
tb/l1i_props.sv
tb/l1i_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the L1I cache simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module l1i_tb -o l1i_sim \
	&& ./obj_dir/l1i_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
